// ==== pe_pkg.sv ====
// shared widths and bus structs for the processing element
// data and psum widths are fixed here; only the pad depths are module parameters
package pe_pkg;

  // ------------------------------------------------
  // widths
  // ------------------------------------------------
  localparam int DATA_WIDTH = 16; // operands and psum_in
  localparam int PSUM_WIDTH = 48; // accumulator, bus word
  localparam int PARA_WIDTH = 8;  // config fields, indices

  // ------------------------------------------------
  // structs
  // ------------------------------------------------
  // latched configuration
  typedef struct packed {
    logic [PARA_WIDTH-1:0] conv_len;   // S*q, 1-D conv length
    logic [PARA_WIDTH-1:0] filter_num; // p, filters in the weight pad
  } pe_cfg_t;

  // tag that rides along with each operand pair
  typedef struct packed {
    logic                  valid;
    logic                  first;  // restart the dot product
    logic                  last;   // emit the sum after this pair
    logic [PARA_WIDTH-1:0] filter; // target psum entry
  } mac_op_t;

  // finished dot product headed for the psum pad
  typedef struct packed {
    logic                  valid;
    logic [PARA_WIDTH-1:0] addr;
    logic [PSUM_WIDTH-1:0] data;
  } psum_wr_t;

endpackage

// ==== operand_pad.sv ====
// operand store with load pointer; load_count must not exceed DEPTH
// words arriving after full are dropped until the next load_start
`timescale 1ns/10ps

module operand_pad #(
  parameter int DEPTH = 36
) (
  input  logic                          clk,
  input  logic                          rst,
  input  logic                          load_start,
  input  logic                          wr_en,
  input  logic [pe_pkg::DATA_WIDTH-1:0] wr_data,
  input  logic [$clog2(DEPTH+1)-1:0]    load_count,
  input  logic [$clog2(DEPTH)-1:0]      rd_addr,
  output logic [pe_pkg::DATA_WIDTH-1:0] rd_data,
  output logic                          full
);
  import pe_pkg::*;

  localparam int AW = $clog2(DEPTH);   // read/write address
  localparam int CW = $clog2(DEPTH+1); // word count, can reach DEPTH

  logic [DATA_WIDTH-1:0] mem [DEPTH];
  logic [CW-1:0]         wr_ptr;
  logic                  wr_ok;

  assign wr_ok = wr_en & ~full & ~load_start; // strobe cycle drops data

  // storage, cleared on reset
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      for (int i = 0; i < DEPTH; i++) begin
        mem[i] <= '0;
      end
    end else if (wr_ok) begin
      mem[wr_ptr[AW-1:0]] <= wr_data;
    end
  end

  // pointer and full flag
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      wr_ptr <= '0;
      full   <= 1'b0;
    end else if (load_start) begin
      wr_ptr <= '0;
      full   <= 1'b0;
    end else if (wr_ok) begin
      wr_ptr <= wr_ptr + 1'b1;
      full   <= (wr_ptr == load_count - 1'b1); // high the cycle after last word
    end
  end

  // registered read, one cycle latency
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      rd_data <= '0;
    end else begin
      rd_data <= mem[rd_addr];
    end
  end

endmodule

// ==== mac_unit.sv ====
// three-stage signed MAC: tag align, multiply, accumulate
// one result per op tagged last, written 3 cycles after that op was issued
`timescale 1ns/10ps

module mac_unit (
  input  logic                          clk,
  input  logic                          rst,
  input  pe_pkg::mac_op_t               op,
  input  logic [pe_pkg::DATA_WIDTH-1:0] weight,
  input  logic [pe_pkg::DATA_WIDTH-1:0] fmap,
  output pe_pkg::psum_wr_t              psum_wr
);
  import pe_pkg::*;

  localparam int PROD_WIDTH = 2 * DATA_WIDTH;

  mac_op_t                      op_d1;    // lines up with pad read data
  mac_op_t                      op_d2;    // lines up with prod
  logic signed [PROD_WIDTH-1:0] prod;
  logic [PSUM_WIDTH-1:0]        prod_ext;
  logic [PSUM_WIDTH-1:0]        acc;
  logic [PSUM_WIDTH-1:0]        sum;

  // tag pipeline
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      op_d1 <= '0;
      op_d2 <= '0;
    end else begin
      op_d1 <= op;
      op_d2 <= op_d1;
    end
  end

  // ------------------------------------------------
  // multiply, then accumulate
  // ------------------------------------------------
  always_ff @(posedge clk) begin
    prod <= $signed(weight) * $signed(fmap);
  end

  assign prod_ext = {{(PSUM_WIDTH-PROD_WIDTH){prod[PROD_WIDTH-1]}}, prod};
  assign sum      = op_d2.first ? prod_ext : acc + prod_ext; // first restarts

  always_ff @(posedge clk) begin
    if (op_d2.valid) begin
      acc <= sum;
    end
  end

  // result write, one cycle pulse on last
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      psum_wr <= '0;
    end else begin
      psum_wr.valid <= op_d2.valid & op_d2.last;
      psum_wr.addr  <= op_d2.filter;
      psum_wr.data  <= sum;
    end
  end

endmodule

// ==== psum_pad.sv ====
// psum storage: MAC results, in-place external accumulate, bus readout
// entries beyond DEPTH alias; filter_num must not exceed DEPTH
`timescale 1ns/10ps

module psum_pad #(
  parameter int DEPTH = 36
) (
  input  logic                          clk,
  input  logic                          rst,
  input  pe_pkg::pe_cfg_t               cfg,
  input  pe_pkg::psum_wr_t              psum_wr,
  input  logic                          acc_en,
  input  logic [pe_pkg::PARA_WIDTH-1:0] acc_index,
  input  logic [pe_pkg::DATA_WIDTH-1:0] psum_in,
  input  logic                          mac_finish,
  input  logic                          psum_acc_finish,
  input  logic                          psum_out_start,
  output logic                          psum_out_en,
  output logic [pe_pkg::PSUM_WIDTH-1:0] psum_to_bus
);
  import pe_pkg::*;

  localparam int AW = $clog2(DEPTH);

  logic [PSUM_WIDTH-1:0] mem [DEPTH];
  logic [PSUM_WIDTH-1:0] psum_in_ext;
  logic [PARA_WIDTH-1:0] rd_cnt;      // next entry to put on the bus
  logic                  ready;       // results waiting for readout
  logic                  out_start;
  logic                  out_done;

  assign psum_in_ext = {{(PSUM_WIDTH-DATA_WIDTH){psum_in[DATA_WIDTH-1]}}, psum_in};
  assign out_start   = psum_out_start & ready & ~psum_out_en & (cfg.filter_num != '0);
  assign out_done    = psum_out_en & (rd_cnt == cfg.filter_num);

  // ------------------------------------------------
  // storage
  // ------------------------------------------------
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      for (int i = 0; i < DEPTH; i++) begin
        mem[i] <= '0;
      end
    end else if (psum_wr.valid) begin
      mem[psum_wr.addr[AW-1:0]] <= psum_wr.data;                      // MAC phase
    end else if (acc_en) begin
      mem[acc_index[AW-1:0]] <= mem[acc_index[AW-1:0]] + psum_in_ext; // acc phase
    end
  end

  // ready set by either finish, cleared once a readout starts
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      ready <= 1'b0;
    end else if (mac_finish | psum_acc_finish) begin
      ready <= 1'b1;
    end else if (out_start) begin
      ready <= 1'b0;
    end
  end

  // ------------------------------------------------
  // bus readout, filter_num words from entry 0
  // ------------------------------------------------
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      psum_out_en <= 1'b0;
      psum_to_bus <= '0;
      rd_cnt      <= '0;
    end else if (out_start) begin
      psum_out_en <= 1'b1;
      psum_to_bus <= mem[0];
      rd_cnt      <= 1'b1;
    end else if (out_done) begin
      psum_out_en <= 1'b0;
      psum_to_bus <= '0; // bus idles at zero
      rd_cnt      <= '0;
    end else if (psum_out_en) begin
      psum_to_bus <= mem[rd_cnt[AW-1:0]];
      rd_cnt      <= rd_cnt + 1'b1;
    end
  end

endmodule

// ==== pe_control.sv ====
// config latch, phase FSM and MAC issue for one PE
// MAC starts only on a rising edge of both-pads-full seen while idle
`timescale 1ns/10ps

module pe_control #(
  parameter int W_PAD_SIZE  = 200,
  parameter int IF_PAD_SIZE = 36
) (
  input  logic                             clk,
  input  logic                             rst,
  input  logic [pe_pkg::PARA_WIDTH-1:0]    cfg_s,
  input  logic [pe_pkg::PARA_WIDTH-1:0]    cfg_q,
  input  logic [pe_pkg::PARA_WIDTH-1:0]    cfg_p,
  input  logic                             start_config,
  input  logic                             start_psum_in_load,
  input  logic                             psum_in_en,
  input  logic                             weight_full,
  input  logic                             fmap_full,
  output pe_pkg::pe_cfg_t                  cfg,
  output logic [$clog2(W_PAD_SIZE+1)-1:0]  weight_load_count,
  output logic [$clog2(IF_PAD_SIZE+1)-1:0] fmap_load_count,
  output logic [$clog2(W_PAD_SIZE)-1:0]    weight_addr,
  output logic [$clog2(IF_PAD_SIZE)-1:0]   fmap_addr,
  output pe_pkg::mac_op_t                  mac_op,
  output logic                             acc_en,
  output logic [pe_pkg::PARA_WIDTH-1:0]    acc_index,
  output logic                             mac_finish,
  output logic                             psum_acc_finish
);
  import pe_pkg::*;

  localparam int WCW = $clog2(W_PAD_SIZE+1);
  localparam int FCW = $clog2(IF_PAD_SIZE+1);
  localparam int FAW = $clog2(IF_PAD_SIZE);

  localparam logic [1:0] ST_IDLE  = 2'd0;
  localparam logic [1:0] ST_ISSUE = 2'd1; // one op per cycle
  localparam logic [1:0] ST_DRAIN = 2'd2; // wait out the MAC pipeline
  localparam logic [1:0] ST_ACC   = 2'd3; // external psum accumulate

  logic [1:0]              state;
  logic [PARA_WIDTH-1:0]   cnt_a;       // position in the 1-D conv
  logic [PARA_WIDTH-1:0]   cnt_b;       // filter index
  logic [1:0]              drain_cnt;
  logic [2*PARA_WIDTH-1:0] w_total;     // conv_len * filter_num, unclipped
  logic                    both_full;
  logic                    both_full_q;
  logic                    mac_begin;
  logic                    a_wrap;
  logic                    b_wrap;
  logic                    acc_last;

  // ------------------------------------------------
  // config
  // ------------------------------------------------
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      cfg <= '0;
    end else if (start_config) begin
      cfg.conv_len   <= PARA_WIDTH'(cfg_s * cfg_q);
      cfg.filter_num <= cfg_p;
    end
  end

  assign w_total           = cfg.conv_len * cfg.filter_num;
  assign weight_load_count = WCW'(w_total);
  assign fmap_load_count   = FCW'(cfg.conv_len); // one full column

  assign both_full = weight_full & fmap_full;
  assign mac_begin = both_full & ~both_full_q & (state == ST_IDLE);
  assign a_wrap    = (cnt_a == cfg.conv_len - 1'b1);
  assign b_wrap    = (cnt_b == cfg.filter_num - 1'b1);
  assign acc_last  = (acc_index == cfg.filter_num - 1'b1);

  // issue outputs, same cycle as the pad addresses
  assign mac_op.valid  = (state == ST_ISSUE);
  assign mac_op.first  = (cnt_a == '0);
  assign mac_op.last   = a_wrap;
  assign mac_op.filter = cnt_b;
  assign fmap_addr     = FAW'(cnt_a);
  assign acc_en        = (state == ST_ACC) & psum_in_en;

  // ------------------------------------------------
  // phase FSM
  // ------------------------------------------------
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      state           <= ST_IDLE;
      cnt_a           <= '0;
      cnt_b           <= '0;
      weight_addr     <= '0;
      drain_cnt       <= '0;
      acc_index       <= '0;
      both_full_q     <= 1'b0;
      mac_finish      <= 1'b0;
      psum_acc_finish <= 1'b0;
    end else begin
      both_full_q     <= both_full;
      mac_finish      <= 1'b0;
      psum_acc_finish <= 1'b0;
      case (state)
        ST_IDLE: begin
          if (mac_begin) begin
            state       <= ST_ISSUE;
            cnt_a       <= '0;
            cnt_b       <= '0;
            weight_addr <= '0;
          end else if (start_psum_in_load) begin
            state     <= ST_ACC;
            acc_index <= '0;
          end
        end
        ST_ISSUE: begin
          weight_addr <= weight_addr + 1'b1; // b*conv_len + a, linear
          if (a_wrap) begin
            cnt_a <= '0;
            cnt_b <= cnt_b + 1'b1;
            if (b_wrap) begin
              state     <= ST_DRAIN;
              drain_cnt <= '0;
            end
          end else begin
            cnt_a <= cnt_a + 1'b1;
          end
        end
        ST_DRAIN: begin
          drain_cnt <= drain_cnt + 1'b1;
          if (drain_cnt == 2'd2) begin
            state      <= ST_IDLE;
            mac_finish <= 1'b1; // 4 cycles after last issue
          end
        end
        default: begin // ST_ACC
          if (acc_en) begin
            acc_index <= acc_index + 1'b1;
            if (acc_last) begin
              state           <= ST_IDLE;
              psum_acc_finish <= 1'b1;
            end
          end
        end
      endcase
    end
  end

endmodule

// ==== pe_top.sv ====
// row-stationary processing element, structural top
// pad depths are set here; S*q and S*q*p must fit the feature and weight pads
`timescale 1ns/10ps

module pe_top #(
  parameter int W_PAD_SIZE  = 200,
  parameter int IF_PAD_SIZE = 36,
  parameter int P_PAD_SIZE  = 36
) (
  input  logic                          clk,
  input  logic                          rst,
  input  logic [pe_pkg::PARA_WIDTH-1:0] cfg_s,
  input  logic [pe_pkg::PARA_WIDTH-1:0] cfg_q,
  input  logic [pe_pkg::PARA_WIDTH-1:0] cfg_p,
  input  logic                          start_config,
  input  logic                          start_weight_load,
  input  logic                          start_feature_load,
  input  logic                          start_psum_in_load,
  input  logic [pe_pkg::DATA_WIDTH-1:0] weight_in,
  input  logic [pe_pkg::DATA_WIDTH-1:0] feature_in,
  input  logic [pe_pkg::DATA_WIDTH-1:0] psum_in,
  input  logic                          weight_in_en,
  input  logic                          feature_in_en,
  input  logic                          psum_in_en,
  input  logic                          psum_out_start,
  output logic                          mac_finish,
  output logic                          psum_acc_finish,
  output logic                          psum_out_en,
  output logic [pe_pkg::PSUM_WIDTH-1:0] psum_to_bus
);
  import pe_pkg::*;

  localparam int WCW = $clog2(W_PAD_SIZE+1);
  localparam int FCW = $clog2(IF_PAD_SIZE+1);
  localparam int WAW = $clog2(W_PAD_SIZE);
  localparam int FAW = $clog2(IF_PAD_SIZE);

  pe_cfg_t               cfg;
  logic [WCW-1:0]        weight_load_count;
  logic [FCW-1:0]        fmap_load_count;
  logic [WAW-1:0]        weight_addr;
  logic [FAW-1:0]        fmap_addr;
  logic [DATA_WIDTH-1:0] weight_rd;
  logic [DATA_WIDTH-1:0] fmap_rd;
  logic                  weight_full;
  logic                  fmap_full;
  mac_op_t               mac_op;
  psum_wr_t              psum_wr;
  logic                  acc_en;
  logic [PARA_WIDTH-1:0] acc_index;

  // ------------------------------------------------
  // control
  // ------------------------------------------------
  pe_control #(
    .W_PAD_SIZE  (W_PAD_SIZE),
    .IF_PAD_SIZE (IF_PAD_SIZE)
  ) u_control (
    .clk                (clk),
    .rst                (rst),
    .cfg_s              (cfg_s),
    .cfg_q              (cfg_q),
    .cfg_p              (cfg_p),
    .start_config       (start_config),
    .start_psum_in_load (start_psum_in_load),
    .psum_in_en         (psum_in_en),
    .weight_full        (weight_full),
    .fmap_full          (fmap_full),
    .cfg                (cfg),
    .weight_load_count  (weight_load_count),
    .fmap_load_count    (fmap_load_count),
    .weight_addr        (weight_addr),
    .fmap_addr          (fmap_addr),
    .mac_op             (mac_op),
    .acc_en             (acc_en),
    .acc_index          (acc_index),
    .mac_finish         (mac_finish),
    .psum_acc_finish    (psum_acc_finish)
  );

  // ------------------------------------------------
  // operand pads, filters stored one after another
  // ------------------------------------------------
  operand_pad #(.DEPTH(W_PAD_SIZE)) u_weight_pad (
    .clk        (clk),
    .rst        (rst),
    .load_start (start_weight_load),
    .wr_en      (weight_in_en),
    .wr_data    (weight_in),
    .load_count (weight_load_count),
    .rd_addr    (weight_addr),
    .rd_data    (weight_rd),
    .full       (weight_full)
  );

  operand_pad #(.DEPTH(IF_PAD_SIZE)) u_fmap_pad (
    .clk        (clk),
    .rst        (rst),
    .load_start (start_feature_load),
    .wr_en      (feature_in_en),
    .wr_data    (feature_in),
    .load_count (fmap_load_count),
    .rd_addr    (fmap_addr),
    .rd_data    (fmap_rd),
    .full       (fmap_full)
  );

  mac_unit u_mac (
    .clk     (clk),
    .rst     (rst),
    .op      (mac_op),
    .weight  (weight_rd),
    .fmap    (fmap_rd),
    .psum_wr (psum_wr)
  );

  psum_pad #(.DEPTH(P_PAD_SIZE)) u_psum_pad (
    .clk             (clk),
    .rst             (rst),
    .cfg             (cfg),
    .psum_wr         (psum_wr),
    .acc_en          (acc_en),
    .acc_index       (acc_index),
    .psum_in         (psum_in),
    .mac_finish      (mac_finish),
    .psum_acc_finish (psum_acc_finish),
    .psum_out_start  (psum_out_start),
    .psum_out_en     (psum_out_en),
    .psum_to_bus     (psum_to_bus)
  );

endmodule

// ==== pe_clk_gen.sv ====
// free-running testbench clock, starts low at time 0
`timescale 1ns/10ps

module pe_clk_gen #(
  parameter int HALF_PERIOD = 5 // ns, 10 ns period
) (
  output logic clk
);

  initial begin
    clk = 1'b0;
  end

  always #(HALF_PERIOD) clk = ~clk;

endmodule

// ==== pe_tb.sv ====
// directed testbench for pe_top; inputs change 1 ns after the rising edge
// outputs are sampled at the same point, after the edge has settled
`timescale 1ns/10ps

module pe_tb;
  import pe_pkg::*;

  localparam int CLK_PERIOD = 10;
  // rough cycle budget per test, used by the watchdog
  localparam int T_IGNORE   = 25;
  localparam int T_SMALL    = 40;
  localparam int T_LARGE    = 160;
  localparam int T_ACC      = 25;
  localparam int T_RELOAD   = 80;
  localparam int RUN_CYCLES = 4 + 2 * T_IGNORE + T_SMALL + T_LARGE + T_ACC + T_RELOAD;
  localparam int WATCHDOG_NS = (3 * RUN_CYCLES + 200) * CLK_PERIOD;

  logic                  clk;
  logic                  rst;
  logic [PARA_WIDTH-1:0] cfg_s, cfg_q, cfg_p;
  logic                  start_config, start_weight_load, start_feature_load;
  logic                  start_psum_in_load;
  logic [DATA_WIDTH-1:0] weight_in, feature_in, psum_in;
  logic                  weight_in_en, feature_in_en, psum_in_en;
  logic                  psum_out_start;
  logic                  mac_finish, psum_acc_finish, psum_out_en;
  logic [PSUM_WIDTH-1:0] psum_to_bus;

  integer          seed = 32'h3e3;
  int              error_count = 0;
  logic [15:0]     w_data [200]; // filters back to back
  logic [15:0]     f_data [36];  // one column
  longint          exp_psum [36];

  pe_clk_gen #(.HALF_PERIOD(CLK_PERIOD / 2)) u_clk_gen (.clk(clk));

  pe_top #(
    .W_PAD_SIZE  (200),
    .IF_PAD_SIZE (36),
    .P_PAD_SIZE  (36)
  ) pe_top_inst (
    .clk(clk), .rst(rst),
    .cfg_s(cfg_s), .cfg_q(cfg_q), .cfg_p(cfg_p),
    .start_config(start_config),
    .start_weight_load(start_weight_load),
    .start_feature_load(start_feature_load),
    .start_psum_in_load(start_psum_in_load),
    .weight_in(weight_in), .feature_in(feature_in), .psum_in(psum_in),
    .weight_in_en(weight_in_en), .feature_in_en(feature_in_en), .psum_in_en(psum_in_en),
    .psum_out_start(psum_out_start),
    .mac_finish(mac_finish), .psum_acc_finish(psum_acc_finish),
    .psum_out_en(psum_out_en), .psum_to_bus(psum_to_bus)
  );

  // --------------------------------------------------
  // helpers
  // --------------------------------------------------
  task step(); // next edge, plus drive/sample offset
    @(posedge clk);
    #1;
  endtask

  task automatic check_value(input string name, input logic [PSUM_WIDTH-1:0] expected,
                             input logic [PSUM_WIDTH-1:0] actual);
    if (expected !== actual) begin
      error_count++;
      $display("MISMATCH time=%0t %s expected=%h actual=%h", $time, name, expected, actual);
      $display("*** FAILED ***");
      $fatal(1, "value check failed");
    end
  endtask

  task automatic configure(input int s, input int q, input int p);
    cfg_s        = PARA_WIDTH'(s);
    cfg_q        = PARA_WIDTH'(q);
    cfg_p        = PARA_WIDTH'(p);
    start_config = 1'b1;
    step();
    start_config = 1'b0;
  endtask

  task automatic fill_operands(input int conv_len, input int filt_num);
    for (int i = 0; i < conv_len * filt_num; i++) w_data[i] = 16'($random(seed));
    for (int i = 0; i < conv_len; i++) f_data[i] = 16'($random(seed));
  endtask

  // clear both full flags together, so no stale pad can trigger the MAC
  task clear_pads();
    start_weight_load  = 1'b1;
    start_feature_load = 1'b1;
    step();
    start_weight_load  = 1'b0;
    start_feature_load = 1'b0;
  endtask

  task automatic load_weights(input int n, input bit with_gaps);
    int i;
    i = 0;
    while (i < n) begin
      if (with_gaps && $random(seed) % 2 != 0) begin
        weight_in_en = 1'b0; // idle cycle in the stream
      end else begin
        weight_in    = w_data[i];
        weight_in_en = 1'b1;
        i++;
      end
      step();
      check_value("mac_finish", 0, mac_finish); // nothing may finish mid-load
    end
    weight_in_en = 1'b0;
  endtask

  task automatic load_features(input int n);
    for (int i = 0; i < n; i++) begin
      feature_in    = f_data[i];
      feature_in_en = 1'b1;
      step();
      check_value("mac_finish", 0, mac_finish);
    end
    feature_in_en = 1'b0;
  endtask

  // returns one cycle after the pulse, once ready is set
  task automatic wait_pulse(input bit use_acc, input int max_cycles);
    int n;
    bit seen;
    n    = 0;
    seen = use_acc ? psum_acc_finish : mac_finish;
    while (!seen && n < max_cycles) begin
      step();
      n++;
      seen = use_acc ? psum_acc_finish : mac_finish;
    end
    if (!seen) begin
      $display("timeout: no %s pulse within %0d cycles",
               use_acc ? "psum_acc_finish" : "mac_finish", max_cycles);
      $display("*** FAILED ***");
      $fatal(1, "finish pulse missing");
    end else begin
      step();
    end
  endtask

  // signed dot product per filter
  task automatic model_dot_products(input int conv_len, input int filt_num);
    longint sum;
    for (int b = 0; b < filt_num; b++) begin
      sum = 0;
      for (int a = 0; a < conv_len; a++) begin
        sum += longint'($signed(w_data[b * conv_len + a])) * longint'($signed(f_data[a]));
      end
      exp_psum[b] = sum;
    end
  endtask

  // strobe, then n words on consecutive cycles, then bus idle
  task automatic read_and_check(input int n);
    psum_out_start = 1'b1;
    step();
    psum_out_start = 1'b0;
    for (int i = 0; i < n; i++) begin
      check_value("psum_out_en", 1, psum_out_en);
      check_value($sformatf("psum_to_bus[%0d]", i), exp_psum[i][PSUM_WIDTH-1:0], psum_to_bus);
      step();
    end
    check_value("psum_out_en", 0, psum_out_en);
    check_value("psum_to_bus", 0, psum_to_bus);
  endtask

  // --------------------------------------------------
  // directed tests
  // --------------------------------------------------
  task test_small_conv();
    configure(3, 1, 2); // conv_len 3, 2 filters
    fill_operands(3, 2);
    clear_pads();
    load_weights(6, 1'b0);
    load_features(3);
    wait_pulse(1'b0, 3 * 2 + 10);
    model_dot_products(3, 2);
    read_and_check(2);
  endtask

  task test_larger_conv();
    configure(4, 3, 5); // conv_len 12, 5 filters
    fill_operands(12, 5);
    w_data[0]  = 16'h8000; // most negative times most negative
    f_data[0]  = 16'h8000;
    w_data[13] = 16'hfff0;
    f_data[11] = 16'hffff;
    clear_pads();
    load_weights(60, 1'b0);
    load_features(12);
    wait_pulse(1'b0, 12 * 5 + 10);
    model_dot_products(12, 5);
    read_and_check(5);
  endtask

  task test_accumulate();
    logic [15:0] word;
    start_psum_in_load = 1'b1;
    step();
    start_psum_in_load = 1'b0;
    for (int i = 0; i < 5; i++) begin
      word        = 16'($random(seed));
      psum_in     = word;
      psum_in_en  = 1'b1;
      exp_psum[i] = exp_psum[i] + longint'($signed(word)); // sign-extended add
      step();
      check_value("psum_acc_finish", (i == 4), psum_acc_finish); // only after the 5th word
    end
    psum_in_en = 1'b0;
    wait_pulse(1'b1, 5);
    read_and_check(5);
  endtask

  task test_ignored_start();
    psum_out_start = 1'b1; // no results waiting
    step();
    psum_out_start = 1'b0;
    repeat (20) begin
      check_value("psum_out_en", 0, psum_out_en);
      step();
    end
  endtask

  task test_reload_order();
    configure(2, 2, 3); // conv_len 4, 3 filters
    fill_operands(4, 3);
    clear_pads();
    load_features(4);  // features first
    load_weights(12, 1'b1); // then weights, with gaps
    wait_pulse(1'b0, 4 * 3 + 10);
    model_dot_products(4, 3);
    read_and_check(3);
  endtask

  // --------------------------------------------------
  // main sequence and watchdog
  // --------------------------------------------------
  initial begin
    rst                = 1'b1;
    cfg_s              = '0;
    cfg_q              = '0;
    cfg_p              = '0;
    start_config       = 1'b0;
    start_weight_load  = 1'b0;
    start_feature_load = 1'b0;
    start_psum_in_load = 1'b0;
    weight_in          = '0;
    feature_in         = '0;
    psum_in            = '0;
    weight_in_en       = 1'b0;
    feature_in_en      = 1'b0;
    psum_in_en         = 1'b0;
    psum_out_start     = 1'b0;
    repeat (4) @(posedge clk);
    #1 rst = 1'b0;
    step();

    test_ignored_start(); // before any finish
    test_small_conv();
    test_larger_conv();
    test_accumulate();
    test_ignored_start(); // after a finished readout
    test_reload_order();

    if (error_count == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("timeout: tests did not complete within %0d ns", WATCHDOG_NS);
    $display("*** FAILED ***");
    $fatal(1, "watchdog expired");
  end

endmodule

// ==== compile.f ====
pe_pkg.sv
operand_pad.sv
mac_unit.sv
psum_pad.sv
pe_control.sv
pe_top.sv
pe_clk_gen.sv
pe_tb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the PE testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing -Wno-fatal -f compile.f --top-module pe_tb -o pe_sim
out=$(./obj_dir/pe_sim || true)
echo "$out"
echo "$out" | grep -qF '*** PASSED ***'
